// File: hdl/pattern_pkg.sv
// **********************************************************
// Pattern writer shared definitions.
// Pixel, coordinate and address types, the sequencer states
// and the pixel size to address shift decode.
// **********************************************************
`default_nettype none

package pattern_pkg;

    typedef logic        [31:0] pixel_t;       // One pixel color word.
    typedef logic signed [13:0] coord_t;       // Signed pixel coordinate.
    typedef logic signed [15:0] dim_t;         // Bitmap width or height.
    typedef logic        [31:0] mem_base_t;    // Bitmap base in pixels.
    typedef logic        [31:0] mem_addr_t;    // Widest byte address.
    typedef logic        [2:0]  pix_bytes_t;   // Bytes per pixel, 1, 2 or 4.
    typedef logic        [1:0]  byte_shift_t;  // Address shift, 0, 1 or 2.

    // Frame scan states.
    typedef enum logic [1:0] {
        SEQ_IDLE,                              // Waiting for a button.
        SEQ_FRAME_START,                       // Rewind the scan.
        SEQ_DRAW                               // One pixel per free cycle.
    } seq_state_t;

    // Turn the pixel size into a left shift for byte addressing.
    function automatic byte_shift_t pixel_shift(input pix_bytes_t bytes);
        byte_shift_t shift;
        case (bytes)
            3'd2:    shift = 2'd1;             // 16 bit pixels.
            3'd4:    shift = 2'd2;             // 32 bit pixels.
            default: shift = 2'd0;             // 8 bit or unknown size.
        endcase
        return shift;
    endfunction

endpackage

`default_nettype wire

// File: hdl/rnd_gen.sv
// **********************************************************
// Free running 32 bit pseudo-random generator.
// XOR of a 37 bit cellular automaton and a 43 bit LFSR.
// **********************************************************
`default_nettype none

module rnd_gen (
    input  logic               CMD_CLK,
    input  logic               reset,
    output pattern_pkg::pixel_t rnd      // Registered random word.
);

    logic [36:0] casr;                   // Cellular automaton, rules 90/150.
    logic [42:0] lfsr;                   // Galois style LFSR.

    // **********************************************************
    // Shift register update.
    // **********************************************************
    always_ff @(posedge CMD_CLK) begin
        if (reset) begin
            casr <= 37'h1_0000_0000;     // Non zero start point.
            lfsr <= 43'h1_0000_0000;
        end else begin
            // Each cell takes its two neighbours, cell 27 also itself.
            casr <= {casr[35:0], casr[36]}
                  ^ {casr[0], casr[36:1]}
                  ^ (37'(casr[27]) << 27);
            // Rotate and feed the top bit into three taps.
            lfsr <= {lfsr[41:0], lfsr[42]}
                  ^ (43'(lfsr[42]) << 41)
                  ^ (43'(lfsr[42]) << 20)
                  ^ (43'(lfsr[42]) << 1);
        end
    end

    // Combine the low words of both generators.
    always_ff @(posedge CMD_CLK) begin
        rnd <= lfsr[31:0] ^ casr[31:0];
    end

endmodule

`default_nettype wire

// File: hdl/pattern_sequencer.sv
// **********************************************************
// Pattern sequencer.
// Samples the buttons, scans the frame x fastest then y and
// picks each pixel color from a counter or from snow.
// **********************************************************
`default_nettype none

module pattern_sequencer (
    input  logic                CMD_CLK,
    input  logic                reset,
    input  logic [1:0]          buttons,        // Active low.
    input  pattern_pkg::dim_t   bitmap_width,
    input  pattern_pkg::dim_t   bitmap_height,
    input  logic                cache_busy,     // Write cache nearly full.
    output logic                draw_valid,     // One cycle per pixel.
    output pattern_pkg::coord_t draw_x,
    output pattern_pkg::coord_t draw_y,
    output pattern_pkg::pixel_t draw_color
);

    import pattern_pkg::*;

    seq_state_t  state;
    logic [1:0]  buttons_l;                     // Sampled buttons.
    coord_t      scan_x, scan_y;                // Next pixel position.
    logic [20:0] pix_cnt;                       // Emitted pixel count.
    logic        cnt_mode;                      // 1 = counter pattern, 0 = snow.
    logic        last_x, last_y;
    pixel_t      rnd;

    rnd_gen i_rnd_gen (
        .CMD_CLK (CMD_CLK),
        .reset   (reset),
        .rnd     (rnd)
    );

    // End of row and end of frame detection.
    always_comb begin
        last_x = dim_t'(scan_x) >= bitmap_width - 16'sd1;
        last_y = dim_t'(scan_y) >= bitmap_height - 16'sd1;
    end

    // **********************************************************
    // Scan FSM.
    // **********************************************************
    always_ff @(posedge CMD_CLK) begin
        if (reset) begin
            buttons_l  <= 2'b11;                // Released.
            state      <= SEQ_IDLE;
            scan_x     <= '0;
            scan_y     <= '0;
            pix_cnt    <= '0;
            cnt_mode   <= 1'b0;
            draw_valid <= 1'b0;
        end else begin
            buttons_l  <= buttons;
            draw_valid <= 1'b0;                 // Pulses only in SEQ_DRAW.
            case (state)
                SEQ_IDLE: begin
                    pix_cnt <= '0;              // Each press restarts the counter.
                    if (buttons_l != 2'b11) state <= SEQ_FRAME_START;
                end
                SEQ_FRAME_START: begin
                    scan_x   <= '0;
                    scan_y   <= '0;
                    cnt_mode <= buttons_l[0];   // Button 1 alone selects the counter.
                    if (buttons_l == 2'b11) state <= SEQ_IDLE;
                    else                    state <= SEQ_DRAW;
                end
                SEQ_DRAW: begin
                    if (!cache_busy) begin
                        draw_valid <= 1'b1;
                        pix_cnt    <= pix_cnt + 21'd1;
                        if (last_x) begin
                            scan_x <= '0;
                            if (last_y) state <= SEQ_FRAME_START;  // Frame done.
                            else        scan_y <= scan_y + 14'sd1;
                        end else begin
                            scan_x <= scan_x + 14'sd1;
                        end
                    end
                end
                default: state <= SEQ_IDLE;
            endcase
        end
    end

    // Pixel payload, valid when draw_valid is high.
    always_ff @(posedge CMD_CLK) begin
        draw_x     <= scan_x;
        draw_y     <= scan_y;
        draw_color <= cnt_mode ? {8'h00, pix_cnt[20:13], pix_cnt[16:1]} : rnd;
    end

endmodule

`default_nettype wire

// File: hdl/pixel_addr_pipe.sv
// **********************************************************
// Pixel address pipeline.
// Three stages from (x, y) to a byte address, base plus
// y times width plus x, scaled by the pixel size.
// **********************************************************
`default_nettype none

module pixel_addr_pipe #(
    parameter int ADDR_W = 24                    // Write address width.
) (
    input  logic                    CMD_CLK,
    input  logic                    reset,
    input  logic                    draw_valid,
    input  pattern_pkg::coord_t     draw_x,
    input  pattern_pkg::coord_t     draw_y,
    input  pattern_pkg::pixel_t     draw_color,
    input  pattern_pkg::mem_base_t  mem_base,    // Bitmap origin in pixels.
    input  pattern_pkg::dim_t       bitmap_width,
    input  pattern_pkg::pix_bytes_t pixel_bytes,
    output logic                    push,
    output logic [ADDR_W-1:0]       push_addr,   // Byte address.
    output pattern_pkg::pixel_t     push_data
);

    import pattern_pkg::*;

    logic        v1, v2;                         // Valid per stage.
    coord_t      x1, y1, x2;
    pixel_t      c1, c2;
    mem_base_t   row2;                           // Row start in pixels.
    byte_shift_t shift;

    always_comb shift = pixel_shift(pixel_bytes);

    // Valid bits.
    always_ff @(posedge CMD_CLK) begin
        if (reset) begin
            v1   <= 1'b0;
            v2   <= 1'b0;
            push <= 1'b0;
        end else begin
            v1   <= draw_valid;
            v2   <= v1;
            push <= v2;
        end
    end

    // **********************************************************
    // Data path.
    // **********************************************************
    always_ff @(posedge CMD_CLK) begin
        // Stage 1 registers the pixel.
        x1 <= draw_x;
        y1 <= draw_y;
        c1 <= draw_color;
        // Stage 2 computes the row address.
        row2 <= mem_base + mem_base_t'(y1 * bitmap_width);
        x2   <= x1;
        c2   <= c1;
        // Stage 3 adds the column and scales to bytes.
        push_addr <= ADDR_W'((row2 + mem_base_t'(x2)) << shift);
        push_data <= c2;
    end

endmodule

`default_nettype wire

// File: hdl/pixel_write_fifo.sv
// **********************************************************
// Pixel write cache.
// Show-ahead FIFO of address and color pairs that feeds the
// memory write port and flags when it is nearly full.
// **********************************************************
`default_nettype none

module pixel_write_fifo #(
    parameter int ADDR_W          = 24,
    parameter int FIFO_DEPTH_LOG2 = 10
) (
    input  logic                CMD_CLK,
    input  logic                reset,
    input  logic                push,
    input  logic [ADDR_W-1:0]   push_addr,
    input  pattern_pkg::pixel_t push_data,
    output logic                cache_busy,   // Almost full.
    input  logic                write_busy,   // Memory port stall.
    output logic                write_req,
    output logic [ADDR_W-1:0]   write_adr,
    output pattern_pkg::pixel_t write_data
);

    import pattern_pkg::*;

    localparam int DEPTH     = 2 ** FIFO_DEPTH_LOG2;
    localparam int AF_MARGIN = 8;              // Room for pixels still in flight.
    localparam int ENTRY_W   = ADDR_W + $bits(pixel_t);
    localparam int CNT_W     = FIFO_DEPTH_LOG2 + 1;

    logic [ENTRY_W-1:0]         ram [DEPTH];
    logic [FIFO_DEPTH_LOG2-1:0] wr_ptr, rd_ptr;
    logic [CNT_W-1:0]           count;         // Entries held.
    logic                       empty, full, wr_en, pop;

    // **********************************************************
    // Flags and memory port.
    // **********************************************************
    always_comb begin
        empty      = count == '0;
        full       = count == CNT_W'(DEPTH);
        cache_busy = count >= CNT_W'(DEPTH - AF_MARGIN);
        write_req  = !empty && !write_busy;    // Never request while busy.
        pop        = write_req;                // Head consumed with the request.
        wr_en      = push && !full;            // Overflow protection.
        {write_adr, write_data} = ram[rd_ptr]; // Head shown ahead of the read.
    end

    always_ff @(posedge CMD_CLK) begin
        if (wr_en) ram[wr_ptr] <= {push_addr, push_data};
    end

    // Pointers and fill count.
    always_ff @(posedge CMD_CLK) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) wr_ptr <= wr_ptr + 1'b1;
            if (pop)   rd_ptr <= rd_ptr + 1'b1;
            case ({wr_en, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;       // Idle or push with pop.
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hdl/draw_test_patterns.sv
// **********************************************************
// Frame pattern writer, top level.
// Fills a bitmap in external memory with snow or a counter
// pattern while a button is held.
// **********************************************************
`default_nettype none

module draw_test_patterns #(
    parameter int ADDR_W          = 24,        // Memory write address width.
    parameter int FIFO_DEPTH_LOG2 = 10         // Write cache depth.
) (
    input  logic                    CMD_CLK,
    input  logic                    reset,
    input  logic [1:0]              buttons,   // Active low.
    input  pattern_pkg::pix_bytes_t pixel_bytes,
    input  pattern_pkg::mem_base_t  mem_base,
    input  pattern_pkg::dim_t       bitmap_width,
    input  pattern_pkg::dim_t       bitmap_height,
    input  logic                    write_busy,
    output logic                    write_req,
    output logic [ADDR_W-1:0]       write_adr,
    output pattern_pkg::pixel_t     write_data
);

    import pattern_pkg::*;

    logic              draw_valid, push, cache_busy;
    coord_t            draw_x, draw_y;
    pixel_t            draw_color, push_data;
    logic [ADDR_W-1:0] push_addr;

    // Frame scan and color choice.
    pattern_sequencer i_sequencer (
        .CMD_CLK       (CMD_CLK),
        .reset         (reset),
        .buttons       (buttons),
        .bitmap_width  (bitmap_width),
        .bitmap_height (bitmap_height),
        .cache_busy    (cache_busy),
        .draw_valid    (draw_valid),
        .draw_x        (draw_x),
        .draw_y        (draw_y),
        .draw_color    (draw_color)
    );

    // Coordinates to byte address.
    pixel_addr_pipe #(.ADDR_W(ADDR_W)) i_addr_pipe (
        .CMD_CLK      (CMD_CLK),
        .reset        (reset),
        .draw_valid   (draw_valid),
        .draw_x       (draw_x),
        .draw_y       (draw_y),
        .draw_color   (draw_color),
        .mem_base     (mem_base),
        .bitmap_width (bitmap_width),
        .pixel_bytes  (pixel_bytes),
        .push         (push),
        .push_addr    (push_addr),
        .push_data    (push_data)
    );

    pixel_write_fifo #(
        .ADDR_W          (ADDR_W),
        .FIFO_DEPTH_LOG2 (FIFO_DEPTH_LOG2)
    ) i_write_fifo (
        .CMD_CLK    (CMD_CLK),
        .reset      (reset),
        .push       (push),
        .push_addr  (push_addr),
        .push_data  (push_data),
        .cache_busy (cache_busy),
        .write_busy (write_busy),
        .write_req  (write_req),
        .write_adr  (write_adr),
        .write_data (write_data)
    );

endmodule

`default_nettype wire

// File: tb/draw_test_patterns_props.sv
// **********************************************************
// Write cache properties, bound into the pixel write FIFO.
// **********************************************************
`default_nettype none

module draw_test_patterns_props (
    input logic CMD_CLK,
    input logic reset,
    input logic push,
    input logic full,
    input logic write_busy,
    input logic write_req
);

    timeunit 1ns;
    timeprecision 100ps;

    int unsigned fail_count = 0;                   // Failed assertions so far.
    int          held;                             // Entries pushed and not yet written.

    // Occupancy seen from the port traffic alone.
    always_ff @(posedge CMD_CLK) begin
        if (reset) held <= 0;
        else       held <= held + int'(push) - int'(write_req);
    end

    a_req_not_busy: assert property (@(posedge CMD_CLK) disable iff (reset)
        write_req |-> !write_busy)
        else begin fail_count++; $error("write_req raised while write_busy"); end

    a_req_not_empty: assert property (@(posedge CMD_CLK) disable iff (reset)
        write_req |-> held > 0)
        else begin fail_count++; $error("write_req raised with an empty cache"); end

    a_no_push_full: assert property (@(posedge CMD_CLK) disable iff (reset)
        push |-> !full)
        else begin fail_count++; $error("push into a full cache"); end

    // Memory port is quiet right after reset.
    a_reset_quiet: assert property (@(posedge CMD_CLK) reset |=> !write_req)
        else begin fail_count++; $error("write_req high after reset"); end

endmodule

bind pixel_write_fifo draw_test_patterns_props i_fifo_props (
    .CMD_CLK    (CMD_CLK),
    .reset      (reset),
    .push       (push),
    .full       (full),
    .write_busy (write_busy),
    .write_req  (write_req)
);

`default_nettype wire

// File: tb/tb_draw_test_patterns.sv
// **********************************************************
// Frame pattern writer testbench.
// Runs a table of frames and checks every memory write
// against the address rule and the counter pattern.
// **********************************************************
`default_nettype none

module tb_draw_test_patterns;

    timeunit 1ns;
    timeprecision 100ps;

    import pattern_pkg::*;

    typedef struct packed {
        logic [1:0] buttons;                        // Active low press.
        pix_bytes_t pix_bytes;
        mem_base_t  base;
        dim_t       width;
        dim_t       height;
        logic       busy_on;                        // Random write_busy.
    } case_t;

    localparam int        N_CASES   = 6;
    localparam mem_addr_t ADDR_MASK = 32'h00FF_FFFF;  // 24 bit port.

    case_t cases [N_CASES] = '{
        '{2'b01, 3'd1, 32'h0000_1000, 16'sd7,  16'sd3, 1'b0},  // Counter, 8 bit.
        '{2'b01, 3'd2, 32'h0000_2000, 16'sd16, 16'sd5, 1'b1},  // Counter again, 16 bit.
        '{2'b10, 3'd4, 32'h0000_0100, 16'sd7,  16'sd3, 1'b1},  // Snow, 32 bit.
        '{2'b10, 3'd1, 32'h00FF_FFF0, 16'sd16, 16'sd5, 1'b0},  // Snow, wraps 24 bits.
        '{2'b01, 3'd4, 32'h0040_0000, 16'sd16, 16'sd5, 1'b1},  // Counter, wraps.
        '{2'b00, 3'd3, 32'h0000_0010, 16'sd5,  16'sd4, 1'b1}   // Both, unknown size.
    };

    logic                CMD_CLK, reset, write_busy, write_req, busy_en;
    logic [1:0]          buttons;
    pix_bytes_t          pixel_bytes;
    mem_base_t           mem_base;
    dim_t                bitmap_width, bitmap_height;
    logic [23:0]         write_adr;
    pixel_t              write_data;
    integer              seed = 24;

    draw_test_patterns #(.ADDR_W(24), .FIFO_DEPTH_LOG2(4)) i_dut (
        .CMD_CLK (CMD_CLK), .reset (reset), .buttons (buttons),
        .pixel_bytes (pixel_bytes), .mem_base (mem_base),
        .bitmap_width (bitmap_width), .bitmap_height (bitmap_height),
        .write_busy (write_busy), .write_req (write_req),
        .write_adr (write_adr), .write_data (write_data)
    );

    always #10 CMD_CLK = ~CMD_CLK;                 // 20 ns period.

    // Memory port model, stalls about 40 % of cycles.
    always @(posedge CMD_CLK) begin
        if (busy_en) write_busy <= ({$random(seed)} % 100) < 40;
        else         write_busy <= 1'b0;
    end

    // **********************************************************
    // Reporting and checks.
    // **********************************************************
    task automatic stop_with_failure();
        $display("Something failed");
        $fatal(1, "Simulation stopped on the first error.");
    endtask

    task automatic report_mismatch(input string msg);
        $display("FAIL at %0t ns: %s", $time, msg);
        stop_with_failure();
    endtask

    task automatic report_timeout(input string msg);
        $display("Timeout while waiting for %s", msg);
        stop_with_failure();
    endtask

    // A cache property that fails ends the run at once.
    always @(posedge CMD_CLK) begin
        if (i_dut.i_write_fifo.i_fifo_props.fail_count != 0) begin
            $display("A write cache assertion failed");
            stop_with_failure();
        end
    end

    task automatic check_addr(input mem_addr_t exp, input mem_addr_t got,
                              input int idx, input int k);
        if (got !== exp)
            report_mismatch($sformatf("case %0d pixel %0d address %h, expected %h",
                                      idx, k, got, exp));
    endtask

    task automatic check_pixel(input pixel_t exp, input pixel_t got,
                               input int idx, input int k);
        if (got !== exp)
            report_mismatch($sformatf("case %0d pixel %0d color %h, expected %h",
                                      idx, k, got, exp));
    endtask

    // Byte address of pixel (x, y), truncated to the port width.
    function automatic mem_addr_t expected_addr(input case_t c, input int x, input int y);
        mem_addr_t pix;
        int        sh;
        pix = c.base + mem_addr_t'(y) * mem_addr_t'(c.width) + mem_addr_t'(x);
        case (c.pix_bytes)
            3'd2:    sh = 1;
            3'd4:    sh = 2;
            default: sh = 0;                       // 8 bit and unknown sizes.
        endcase
        return (pix << sh) & ADDR_MASK;
    endfunction

    // Counter pattern, zero top byte, bits 20..13 then 16..1.
    function automatic pixel_t counter_color(input int k);
        return (pixel_t'((k >> 13) & 'hFF) << 16) | pixel_t'((k >> 1) & 'hFFFF);
    endfunction

    // Next write accepted by the memory port.
    task automatic wait_write(output mem_addr_t addr, output pixel_t data, input int idx,
                              input int k);
        int cycles;
        bit got;
        cycles = 0;
        got    = 1'b0;
        while (!got) begin
            @(posedge CMD_CLK);
            if (write_req) begin
                addr = mem_addr_t'(write_adr);
                data = write_data;
                got  = 1'b1;
            end else if (++cycles >= 2000) begin
                report_timeout($sformatf("write of pixel %0d in case %0d", k, idx));
            end
        end
    endtask

    // Port idle for 64 cycles in a row.
    task automatic wait_quiet(input int idx);
        int quiet;
        int cycles;
        quiet  = 0;
        cycles = 0;
        while (quiet < 64) begin
            @(posedge CMD_CLK);
            quiet = write_req ? 0 : quiet + 1;
            if (++cycles >= 5000)
                report_timeout($sformatf("write_req to go quiet after case %0d", idx));
        end
    endtask

    // **********************************************************
    // One table row, a single checked frame.
    // **********************************************************
    task automatic run_case(input int idx);
        case_t     c;
        mem_addr_t got_addr;
        pixel_t    got_data, first_color;
        bit        colors_differ;
        int        n_pix;
        c             = cases[idx];
        colors_differ = 1'b0;
        first_color   = '0;
        n_pix         = int'(c.width) * int'(c.height);
        @(posedge CMD_CLK);
        pixel_bytes   <= c.pix_bytes;              // Config with buttons released.
        mem_base      <= c.base;
        bitmap_width  <= c.width;
        bitmap_height <= c.height;
        busy_en       <= c.busy_on;
        @(posedge CMD_CLK);
        buttons <= c.buttons;
        for (int k = 0; k < n_pix; k++) begin
            wait_write(got_addr, got_data, idx, k);
            check_addr(expected_addr(c, k % int'(c.width), k / int'(c.width)),
                       got_addr, idx, k);
            if (c.buttons == 2'b01) check_pixel(counter_color(k), got_data, idx, k);
            else if (k == 0)        first_color = got_data;
            else if (got_data !== first_color) colors_differ = 1'b1;
        end
        @(posedge CMD_CLK);
        buttons <= 2'b11;
        busy_en <= 1'b0;                           // Let the cache drain freely.
        if (c.buttons != 2'b01 && !colors_differ)
            report_mismatch($sformatf("case %0d snow colors are all equal", idx));
        wait_quiet(idx);
    endtask

    initial begin
        CMD_CLK       = 1'b0;
        reset         = 1'b1;
        buttons       = 2'b11;
        pixel_bytes   = 3'd1;
        mem_base      = '0;
        bitmap_width  = 16'sd1;
        bitmap_height = 16'sd1;
        write_busy    = 1'b0;
        busy_en       = 1'b0;
        repeat (5) @(posedge CMD_CLK);
        reset <= 1'b0;
        for (int i = 0; i < N_CASES; i++) run_case(i);
        if (i_dut.i_write_fifo.i_fifo_props.fail_count != 0) begin
            $display("Cache assertions failed %0d times",
                     i_dut.i_write_fifo.i_fifo_props.fail_count);
            stop_with_failure();
        end else begin
            $display("Everything OK");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: list.f
hdl/pattern_pkg.sv
hdl/rnd_gen.sv
hdl/pattern_sequencer.sv
hdl/pixel_addr_pipe.sv
hdl/pixel_write_fifo.sv
hdl/draw_test_patterns.sv
tb/draw_test_patterns_props.sv
tb/tb_draw_test_patterns.sv
